// ==== peripheral_bus.f ====
+incdir+bench
logic/periph_pkg.sv
logic/io_port_decoder.sv
logic/ems_mapper.sv
logic/lpt_port.sv
logic/bus_read_mux.sv
logic/peripheral_bus.sv
bench/peripheral_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the peripheral bus testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f peripheral_bus.f \
    --top-module peripheral_bus_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vperipheral_bus_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -q '^PASS: all tests$'; then
    exit 0
fi
exit 1

// ==== bench/peripheral_bus_tests.svh ====
/*
 * Directed tests of the peripheral bus
 * Device selects, EMS registers and windows, printer port, chipset read flag
 */

// Index order: dma, pic, pit, ppi, dma_page, tandy, opl, uart
function automatic periph_pkg::device_select_t only_select(input int unsigned which);
    periph_pkg::device_select_t s;
    s = '1;
    case (which)
        0:       s.dma         = 1'b0;
        1:       s.pic         = 1'b0;
        2:       s.pit         = 1'b0;
        3:       s.ppi         = 1'b0;
        4:       s.dma_page    = 1'b0;
        5:       s.tandy_sound = 1'b0;
        6:       s.opl         = 1'b0;
        7:       s.uart        = 1'b0;
        default: s             = '1;
    endcase
    return s;
endfunction

function automatic logic [periph_pkg::ADDR_W-1:0] frame_base(input logic [1:0] setting);
    case (setting)
        2'd0:    return 20'hA0000;
        2'd1:    return 20'hC0000;
        default: return 20'hD0000;
    endcase
endfunction

task automatic io_write(input logic [periph_pkg::ADDR_W-1:0] address,
                        input logic [periph_pkg::DATA_W-1:0] data, input logic expect_covox);
    drive_bus(make_bus(address, data, 1'b1, 1'b0, 1'b1, 1'b0));
    compare_flag("covox_write", covox_write, expect_covox);
    drive_bus(idle_bus());
endtask

task automatic check_read(input logic [periph_pkg::ADDR_W-1:0] address,
                          input logic [periph_pkg::DATA_W-1:0] data, input logic flag);
    io_read(address);
    compare_byte("read_data", read_data, data);
    compare_flag("read_from_chipset", read_from_chipset, flag);
endtask

task automatic device_select_test();
    int unsigned          raw;
    periph_pkg::cpu_bus_t random_bus;
    $display("test: device selects");
    io_read(20'h00000);
    compare_select("device_select dma", device_select, only_select(0));
    io_read(20'h00020);
    compare_select("device_select pic", device_select, only_select(1));
    io_read(20'h00040);
    compare_select("device_select pit", device_select, only_select(2));
    io_read(20'h00060);
    compare_select("device_select ppi", device_select, only_select(3));
    io_read(20'h00080);
    compare_select("device_select page", device_select, only_select(4));
    io_read(20'h000C0);
    compare_select("device_select tandy", device_select, only_select(5));
    io_read(20'h00388);
    compare_select("device_select opl", device_select, only_select(6));
    io_read(20'h003F8);
    compare_select("device_select uart", device_select, only_select(7));
    memory_read(20'h00020);
    compare_select("device_select memory", device_select, '1);
    drive_bus(make_bus(20'h00020, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1));
    compare_select("device_select aen high", device_select, '1);
    for (int i = 0; i < 64; i++) begin
        raw = $urandom();
        random_bus = make_bus(raw[19:0], 8'h00, raw[20], 1'b1, raw[22], raw[21]);
        drive_bus(random_bus);
        compare_select("device_select random", device_select, expected_select(random_bus));
    end
    drive_bus(idle_bus());
endtask

task automatic ems_register_test();
    $display("test: EMS registers");
    @(posedge clock);
    ems_enabled <= 1'b1;
    check_read(20'h00260, 8'hFF, 1'b1);
    check_read(20'h00261, 8'hFF, 1'b1);
    check_read(20'h00262, 8'hFF, 1'b1);
    check_read(20'h00263, 8'hFF, 1'b1);
    io_write(20'h00261, 8'h05, 1'b0);
    check_read(20'h00261, 8'h05, 1'b1);
    // 90h is neither a page number nor the unmap code
    io_write(20'h00261, 8'h90, 1'b0);
    check_read(20'h00261, 8'h05, 1'b1);
    io_write(20'h00261, 8'hFF, 1'b0);
    check_read(20'h00261, 8'hFF, 1'b1);
    @(posedge clock);
    ems_enabled <= 1'b0;
    io_write(20'h00262, 8'h07, 1'b0);
    check_read(20'h00262, 8'h00, 1'b0);
    @(posedge clock);
    ems_enabled <= 1'b1;
    check_read(20'h00262, 8'hFF, 1'b1);
endtask

task automatic ems_window_test();
    logic [periph_pkg::ADDR_W-1:0]      offset;
    logic [periph_pkg::EMS_WINDOWS-1:0] expected;
    $display("test: EMS windows");
    io_write(20'h00260, 8'h10, 1'b0);
    io_write(20'h00261, 8'hFF, 1'b0);
    io_write(20'h00262, 8'h22, 1'b0);
    io_write(20'h00263, 8'hFF, 1'b0);
    for (int f = 0; f < 4; f++) begin
        @(posedge clock);
        ems_frame <= f[1:0];
        offset = 20'h00000;
        for (int k = 0; k < periph_pkg::EMS_WINDOWS; k++) begin
            expected = 4'b0101 & (4'b0001 << k);
            memory_read(frame_base(f[1:0]) + offset);
            compare_window("ems_window base", ems_window, expected);
            memory_read(frame_base(f[1:0]) + offset + 20'h03FFF);
            compare_window("ems_window top", ems_window, expected);
            io_read(frame_base(f[1:0]) + offset);
            compare_window("ems_window io", ems_window, 4'b0000);
            offset = offset + 20'h04000;
        end
        memory_read(frame_base(f[1:0]) + 20'h10000);
        compare_window("ems_window outside", ems_window, 4'b0000);
    end
    drive_bus(idle_bus());
endtask

task automatic printer_port_test();
    $display("test: printer port");
    check_read(20'h00378, 8'hFF, 1'b1);
    io_write(20'h00378, 8'h5A, 1'b0);
    check_read(20'h00378, 8'h5A, 1'b1);
    @(posedge clock);
    dss_full <= 1'b1;
    check_read(20'h00379, 8'h40, 1'b1);
    @(posedge clock);
    dss_full <= 1'b0;
    check_read(20'h00379, 8'h00, 1'b1);
    @(posedge clock);
    covox_enable <= 1'b1;
    io_write(20'h00378, 8'hA5, 1'b1);
    check_read(20'h00378, 8'hA5, 1'b1);
    compare_flag("covox_write", covox_write, 1'b0);
    io_write(20'h00379, 8'h33, 1'b0);
    check_read(20'h00378, 8'hA5, 1'b1);
    @(posedge clock);
    covox_enable <= 1'b0;
endtask

task automatic chipset_flag_test();
    $display("test: chipset read flag");
    drive_bus(idle_bus());
    compare_byte("read_data", read_data, 8'h00);
    compare_flag("read_from_chipset", read_from_chipset, 1'b0);
    check_read(20'h00020, 8'h00, 1'b1);
    check_read(20'h00040, 8'h00, 1'b1);
    check_read(20'h00000, 8'h00, 1'b0);
    @(posedge clock);
    interrupt_acknowledge_n <= 1'b0;
    drive_bus(idle_bus());
    compare_byte("read_data", read_data, 8'h00);
    compare_flag("read_from_chipset", read_from_chipset, 1'b1);
    @(posedge clock);
    interrupt_acknowledge_n <= 1'b1;
    drive_bus(make_bus(20'h00020, 8'h13, 1'b1, 1'b0, 1'b1, 1'b0));
    compare_flag("read_from_chipset", read_from_chipset, 1'b0);
    drive_bus(idle_bus());
endtask

// ==== bench/peripheral_bus_tb.sv ====
/*
 * Peripheral bus testbench
 * Clock, reset, bus drivers, compare tasks and the closing report
 */
`timescale 1ns/10ps

module peripheral_bus_tb;

    logic                               clock;
    logic                               reset;
    periph_pkg::cpu_bus_t               bus;
    logic                               interrupt_acknowledge_n;
    logic                               ems_enabled;
    logic [1:0]                         ems_frame;
    logic                               covox_enable;
    logic                               dss_full;
    periph_pkg::device_select_t         device_select;
    logic [periph_pkg::EMS_WINDOWS-1:0] ems_window;
    logic                               covox_write;
    logic [periph_pkg::DATA_W-1:0]      read_data;
    logic                               read_from_chipset;
    int                                 error_count;
    int                                 check_count;

    peripheral_bus #(
        .EMS_PORT_BASE (16'h0260),
        .LPT_BASE      (16'h0378)
    ) dut (
        .clock                     (clock),
        .reset                     (reset),
        .bus_i                     (bus),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n),
        .ems_enabled_i             (ems_enabled),
        .ems_frame_i               (ems_frame),
        .covox_enable_i            (covox_enable),
        .dss_full_i                (dss_full),
        .device_select_o           (device_select),
        .ems_window_o              (ems_window),
        .covox_write_o             (covox_write),
        .read_data_o               (read_data),
        .read_from_chipset_o       (read_from_chipset)
    );

    always #50 clock = ~clock;

    function automatic periph_pkg::cpu_bus_t make_bus(
        input logic [periph_pkg::ADDR_W-1:0] address,
        input logic [periph_pkg::DATA_W-1:0] data,
        input logic                          io_read_n,
        input logic                          io_write_n,
        input logic                          memory_read_n,
        input logic                          address_enable_n
    );
        periph_pkg::cpu_bus_t b;
        b.address          = address;
        b.write_data       = data;
        b.io_read_n        = io_read_n;
        b.io_write_n       = io_write_n;
        b.memory_read_n    = memory_read_n;
        b.address_enable_n = address_enable_n;
        return b;
    endfunction

    function automatic periph_pkg::cpu_bus_t idle_bus();
        return make_bus(20'h00000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1);
    endfunction

    // New bus value on the rising edge, outputs looked at on the falling edge
    task automatic drive_bus(input periph_pkg::cpu_bus_t value);
        @(posedge clock);
        bus <= value;
        @(negedge clock);
    endtask

    task automatic io_read(input logic [periph_pkg::ADDR_W-1:0] address);
        drive_bus(make_bus(address, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0));
    endtask

    task automatic memory_read(input logic [periph_pkg::ADDR_W-1:0] address);
        drive_bus(make_bus(address, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0));
    endtask

    task automatic compare_select(input string name, input periph_pkg::device_select_t actual,
                                  input periph_pkg::device_select_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_byte(input string name, input logic [periph_pkg::DATA_W-1:0] actual,
                                input logic [periph_pkg::DATA_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_window(input string name,
                                  input logic [periph_pkg::EMS_WINDOWS-1:0] actual,
                                  input logic [periph_pkg::EMS_WINDOWS-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Reference decode of the controller selects
    function automatic periph_pkg::device_select_t expected_select(
        input periph_pkg::cpu_bus_t b
    );
        periph_pkg::device_select_t s;
        logic                       request;
        logic [15:0]                port;
        s       = '1;
        request = (b.io_read_n == 1'b0) || (b.io_write_n == 1'b0);
        port    = b.address[15:0];
        if (request && !b.address_enable_n && b.address[9:8] == 2'b00) begin
            case (b.address[7:5])
                3'd0:    s.dma      = 1'b0;
                3'd1:    s.pic      = 1'b0;
                3'd2:    s.pit      = 1'b0;
                3'd3:    s.ppi      = 1'b0;
                3'd4:    s.dma_page = 1'b0;
                default: s          = '1;
            endcase
        end
        if (request && port >= 16'h00C0 && port <= 16'h00C7) s.tandy_sound = 1'b0;
        if (request && (port == 16'h0388 || port == 16'h0389)) s.opl = 1'b0;
        if (request && port >= 16'h03F8 && port <= 16'h03FF) s.uart = 1'b0;
        return s;
    endfunction

    task automatic wait_for_idle_outputs();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (reset || ems_window != '0 || read_from_chipset) begin
            if (cycles == 10) begin
                error_count++;
                $display("ERROR: outputs did not go idle within 10 cycles after reset");
                return;
            end
            cycles++;
            @(negedge clock);
        end
    endtask

    `include "peripheral_bus_tests.svh"

    initial begin
        void'($urandom(32'h1675));
        error_count = 0;
        check_count = 0;
        clock = 1'b0;
        reset <= 1'b1;
        bus <= idle_bus();
        interrupt_acknowledge_n <= 1'b1;
        ems_enabled <= 1'b0;
        ems_frame <= 2'd0;
        covox_enable <= 1'b0;
        dss_full <= 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        wait_for_idle_outputs();
        compare_byte("read_data", read_data, 8'h00);

        device_select_test();
        ems_register_test();
        ems_window_test();
        printer_port_test();
        chipset_flag_test();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== logic/peripheral_bus.sv ====
/*
 * Peripheral bus top
 * I/O decode, EMS mapper, printer port and CPU read data of the system board
 */
`timescale 1ns/10ps

module peripheral_bus #(
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260,
    parameter logic [15:0] LPT_BASE      = 16'h0378
) (
    input  logic                               clock,
    input  logic                               reset,
    input  periph_pkg::cpu_bus_t               bus_i,
    input  logic                               interrupt_acknowledge_n_i,
    input  logic                               ems_enabled_i,
    input  logic [1:0]                         ems_frame_i,
    input  logic                               covox_enable_i,
    input  logic                               dss_full_i,
    output periph_pkg::device_select_t         device_select_o,
    output logic [periph_pkg::EMS_WINDOWS-1:0] ems_window_o,
    output logic                               covox_write_o,
    output logic [periph_pkg::DATA_W-1:0]      read_data_o,
    output logic                               read_from_chipset_o
);

    periph_pkg::local_hit_t          local_hit;
    logic [periph_pkg::DATA_W-1:0]   ems_byte;
    logic [periph_pkg::DATA_W-1:0]   lpt_data;
    logic [periph_pkg::DATA_W-1:0]   lpt_status;

    io_port_decoder #(
        .EMS_PORT_BASE (EMS_PORT_BASE),
        .LPT_BASE      (LPT_BASE)
    ) u_io_port_decoder (
        .bus_i           (bus_i),
        .ems_enabled_i   (ems_enabled_i),
        .device_select_o (device_select_o),
        .local_hit_o     (local_hit)
    );

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .port_hit_i   (local_hit.ems_port),
        .ems_frame_i  (ems_frame_i),
        .ems_window_o (ems_window_o),
        .read_byte_o  (ems_byte)
    );

    lpt_port u_lpt_port (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus_i),
        .data_hit_i     (local_hit.lpt_data),
        .covox_enable_i (covox_enable_i),
        .dss_full_i     (dss_full_i),
        .data_byte_o    (lpt_data),
        .status_byte_o  (lpt_status),
        .covox_write_o  (covox_write_o)
    );

    bus_read_mux u_bus_read_mux (
        .bus_i                     (bus_i),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .device_select_i           (device_select_o),
        .local_hit_i               (local_hit),
        .ems_byte_i                (ems_byte),
        .lpt_data_i                (lpt_data),
        .lpt_status_i              (lpt_status),
        .read_data_o               (read_data_o),
        .read_from_chipset_o       (read_from_chipset_o)
    );

endmodule

// ==== logic/bus_read_mux.sv ====
/*
 * CPU read data multiplexer
 * Picks the byte for an I/O read and flags when the chipset drives the bus
 */
`timescale 1ns/10ps

module bus_read_mux (
    input  periph_pkg::cpu_bus_t          bus_i,
    input  logic                          interrupt_acknowledge_n_i,
    input  periph_pkg::device_select_t    device_select_i,
    input  periph_pkg::local_hit_t        local_hit_i,
    input  logic [periph_pkg::DATA_W-1:0] ems_byte_i,
    input  logic [periph_pkg::DATA_W-1:0] lpt_data_i,
    input  logic [periph_pkg::DATA_W-1:0] lpt_status_i,
    output logic [periph_pkg::DATA_W-1:0] read_data_o,
    output logic                          read_from_chipset_o
);

    logic io_read;
    logic external_read;

    assign io_read = !bus_i.io_read_n;

    // PIC, PIT and PPI live outside this block, their data is not returned
    assign external_read = io_read &&
        (!device_select_i.pic || !device_select_i.pit || !device_select_i.ppi);

    always_comb begin
        read_data_o         = '0;
        read_from_chipset_o = 1'b0;
        if (!interrupt_acknowledge_n_i) begin
            read_from_chipset_o = 1'b1;
        end else if (io_read && local_hit_i.ems_port) begin
            read_from_chipset_o = 1'b1;
            read_data_o         = ems_byte_i;
        end else if (io_read && local_hit_i.lpt_data) begin
            read_from_chipset_o = 1'b1;
            read_data_o         = lpt_data_i;
        end else if (io_read && local_hit_i.lpt_status) begin
            read_from_chipset_o = 1'b1;
            read_data_o         = lpt_status_i;
        end else if (external_read) begin
            read_from_chipset_o = 1'b1;
        end
    end

endmodule

// ==== logic/lpt_port.sv ====
/*
 * Parallel port
 * Data latch, status byte with the sound FIFO full flag, sample write strobe
 */
`timescale 1ns/10ps

module lpt_port (
    input  logic                          clock,
    input  logic                          reset,
    input  periph_pkg::cpu_bus_t          bus_i,
    input  logic                          data_hit_i,
    input  logic                          covox_enable_i,
    input  logic                          dss_full_i,
    output logic [periph_pkg::DATA_W-1:0] data_byte_o,
    output logic [periph_pkg::DATA_W-1:0] status_byte_o,
    output logic                          covox_write_o
);

    logic data_write;

    assign data_write = data_hit_i && !bus_i.io_write_n;

    // Idle printer lines read back high
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_byte_o <= 8'hFF;
        end else if (data_write) begin
            data_byte_o <= bus_i.write_data;
        end
    end

    // Only the ACK position is used, it reports the DSS FIFO full
    assign status_byte_o = {1'b0, dss_full_i, 6'b000000};

    // Sample player takes every byte written while enabled
    assign covox_write_o = data_write && covox_enable_i;

    // Data hit from the decoder needs an I/O cycle
    data_hit_in_io_cycle: assert property (@(posedge clock) disable iff (reset)
        data_hit_i |-> (!bus_i.io_read_n || !bus_i.io_write_n));

endmodule

// ==== logic/ems_mapper.sv ====
/*
 * EMS page mapper
 * Four page registers behind the EMS ports and the window hits in the page frame
 */
`timescale 1ns/10ps

module ems_mapper (
    input  logic                               clock,
    input  logic                               reset,
    input  periph_pkg::cpu_bus_t               bus_i,
    input  logic                               port_hit_i,
    input  logic [1:0]                         ems_frame_i,
    output logic [periph_pkg::EMS_WINDOWS-1:0] ems_window_o,
    output logic [periph_pkg::DATA_W-1:0]      read_byte_o
);

    logic [periph_pkg::EMS_PAGE_W-1:0]          page_q [periph_pkg::EMS_WINDOWS];
    logic [periph_pkg::EMS_WINDOWS-1:0]         enable_q;
    logic [$clog2(periph_pkg::EMS_WINDOWS)-1:0] page_index;
    logic                                       io_request;
    logic [3:0]                                 frame_nibble;
    periph_pkg::ems_cmd_e                       write_cmd;
    periph_pkg::ems_frame_e                     frame;

    assign io_request = !bus_i.io_read_n || !bus_i.io_write_n;
    assign page_index = bus_i.address[1:0];

    // FFh unmaps, bytes below 80h map, the rest are ignored
    always_comb begin
        if (bus_i.write_data == 8'hFF) begin
            write_cmd = periph_pkg::EMS_CMD_UNMAP;
        end else if (bus_i.write_data < 8'h80) begin
            write_cmd = periph_pkg::EMS_CMD_MAP;
        end else begin
            write_cmd = periph_pkg::EMS_CMD_IGNORE;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < periph_pkg::EMS_WINDOWS; i++) begin
                page_q[i] <= '0;
            end
            enable_q <= '0;
        end else if (port_hit_i && !bus_i.io_write_n) begin
            case (write_cmd)
                periph_pkg::EMS_CMD_MAP: begin
                    page_q[page_index]   <= bus_i.write_data[periph_pkg::EMS_PAGE_W-1:0];
                    enable_q[page_index] <= 1'b1;
                end
                periph_pkg::EMS_CMD_UNMAP: begin
                    page_q[page_index]   <= '1;
                    enable_q[page_index] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    assign read_byte_o = enable_q[page_index] ?
        {{(periph_pkg::DATA_W - periph_pkg::EMS_PAGE_W){1'b0}}, page_q[page_index]} : 8'hFF;

    // Input value 3 falls back to the D000 frame
    always_comb begin
        case (ems_frame_i)
            2'd0:    frame = periph_pkg::FRAME_A000;
            2'd1:    frame = periph_pkg::FRAME_C000;
            default: frame = periph_pkg::FRAME_D000;
        endcase
        case (frame)
            periph_pkg::FRAME_A000: frame_nibble = 4'hA;
            periph_pkg::FRAME_C000: frame_nibble = 4'hC;
            default:                frame_nibble = 4'hD;
        endcase
    end

    // 16 KB windows, consecutive inside the 64 KB frame
    always_comb begin
        for (int k = 0; k < periph_pkg::EMS_WINDOWS; k++) begin
            ems_window_o[k] = !io_request && enable_q[k] &&
                              bus_i.address[19:14] == {frame_nibble, 2'(k)};
        end
    end

    window_quiet_during_io: assert property (@(posedge clock) disable iff (reset)
        io_request |-> ems_window_o == '0);

    // The decoder only reports a port hit inside an I/O cycle
    port_hit_in_io_cycle: assert property (@(posedge clock) disable iff (reset)
        port_hit_i |-> io_request);

endmodule

// ==== logic/io_port_decoder.sv ====
/*
 * I/O port decoder
 * Chip selects for the external controllers and hits on local registers
 */
`timescale 1ns/10ps

module io_port_decoder #(
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260,
    parameter logic [15:0] LPT_BASE      = 16'h0378
) (
    input  periph_pkg::cpu_bus_t       bus_i,
    input  logic                       ems_enabled_i,
    output periph_pkg::device_select_t device_select_o,
    output periph_pkg::local_hit_t     local_hit_o
);

    logic        io_request;
    logic        board_space;
    logic [15:0] io_address;
    logic [15:0] lpt_status_port;

    assign io_request      = !bus_i.io_read_n || !bus_i.io_write_n;
    assign io_address      = bus_i.address[15:0];
    assign lpt_status_port = LPT_BASE + 16'd1;

    // Motherboard devices sit in the first 256 ports, 32 ports each
    assign board_space = io_request && !bus_i.address_enable_n &&
                         !bus_i.address[9] && !bus_i.address[8];

    always_comb begin
        device_select_o = '1;
        if (board_space) begin
            case (bus_i.address[7:5])
                3'd0:    device_select_o.dma      = 1'b0;
                3'd1:    device_select_o.pic      = 1'b0;
                3'd2:    device_select_o.pit      = 1'b0;
                3'd3:    device_select_o.ppi      = 1'b0;
                3'd4:    device_select_o.dma_page = 1'b0;
                default: device_select_o.dma      = 1'b1;
            endcase
        end

        // C0h..C7h
        device_select_o.tandy_sound =
            !(io_request && {io_address[15:3], 3'b000} == periph_pkg::TANDY_PORT);
        // 388h..389h
        device_select_o.opl =
            !(io_request && {io_address[15:1], 1'b0} == periph_pkg::OPL_PORT);
        // 3F8h..3FFh
        device_select_o.uart =
            !(io_request && {io_address[15:3], 3'b000} == periph_pkg::UART_PORT);
    end

    always_comb begin
        local_hit_o.ems_port   = io_request && ems_enabled_i &&
                                 {io_address[15:2], 2'b00} == EMS_PORT_BASE;
        local_hit_o.lpt_data   = io_request && io_address == LPT_BASE;
        local_hit_o.lpt_status = io_request && io_address == lpt_status_port;
    end

    // Address ranges of the controllers never overlap
    always_comb begin
        assert ($onehot0(~device_select_o))
        else $error("more than one device select active: %h", device_select_o);
    end

endmodule

// ==== logic/periph_pkg.sv ====
/*
 * Peripheral bus definitions
 * CPU bus cycle view, device selects, local register hits and EMS types
 */
package periph_pkg;

    parameter int ADDR_W      = 20;
    parameter int DATA_W      = 8;
    parameter int EMS_PAGE_W  = 7;
    parameter int EMS_WINDOWS = 4;

    // Fixed ports of the external sound and serial devices
    parameter logic [15:0] TANDY_PORT = 16'h00C0;
    parameter logic [15:0] OPL_PORT   = 16'h0388;
    parameter logic [15:0] UART_PORT  = 16'h03F8;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] write_data;
        logic              io_read_n;
        logic              io_write_n;
        logic              memory_read_n;
        logic              address_enable_n;
    } cpu_bus_t;

    // Active low, one per external controller
    typedef struct packed {
        logic dma;
        logic dma_page;
        logic pic;
        logic pit;
        logic ppi;
        logic tandy_sound;
        logic opl;
        logic uart;
    } device_select_t;

    // Active high hits on registers held in this block
    typedef struct packed {
        logic ems_port;
        logic lpt_data;
        logic lpt_status;
    } local_hit_t;

    typedef enum logic [1:0] {
        FRAME_A000 = 2'd0,
        FRAME_C000 = 2'd1,
        FRAME_D000 = 2'd2
    } ems_frame_e;

    typedef enum logic [1:0] {
        EMS_CMD_MAP    = 2'd0,
        EMS_CMD_UNMAP  = 2'd1,
        EMS_CMD_IGNORE = 2'd2
    } ems_cmd_e;

endpackage
